// ==== sim/datapathAsserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathAsserts import datapathPkg::*; #(
    parameter int numRegs = 16
) (
    input  logic    clock,
    input  logic    rst,
    input  dpCtrl_t ctrl,
    input  word_t   pc,
    input  word_t   ir,
    input  word_t   mar,
    input  word_t   mdr,
    input  word_t   y,
    input  dword_t  z,
    input  word_t   hi,
    input  word_t   lo,
    input  word_t   regQ [numRegs]
);

    logic allClear;
    int   failures = 0; // Failed assertion count

    // Every register of the datapath at zero
    always_comb begin
        allClear = (pc == '0) && (ir == '0) && (mar == '0) && (mdr == '0);
        allClear = allClear && (y == '0) && (z == '0) && (hi == '0) && (lo == '0);
        for (int i = 0; i < numRegs; i++) begin
            if (regQ[i] != '0) begin
                allClear = 1'b0;
            end
        end
    end

    // One bus driver per cycle
    oneSource: assert property (@(posedge clock) disable iff (rst) $onehot0(ctrl.src))
        else begin
            failures++;
            $error("more than one bus source strobe is high");
        end

    readWithMdr: assert property (@(posedge clock) disable iff (rst)
        ctrl.read |-> ctrl.dst.mdrIn)
        else begin
            failures++;
            $error("memory read strobe high without mdrIn");
        end

    resetClear: assert property (@(posedge clock) rst |=> allClear)
        else begin
            failures++;
            $error("a register is not zero after reset");
        end

endmodule

bind datapath datapathAsserts #(
    .numRegs(numRegs)
) chk (
    .clock(clock),
    .rst  (rst),
    .ctrl (ctrl),
    .pc   (pc),
    .ir   (ir),
    .mar  (mar),
    .mdr  (mdr),
    .y    (y),
    .z    (z),
    .hi   (hi),
    .lo   (lo),
    .regQ (regQ)
);

`default_nettype wire

// ==== sim/datapathTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathTb import datapathPkg::*; ();

    logic    clock;
    logic    rst;
    dpCtrl_t ctrl;
    word_t   mdataIn;
    word_t   busOut;
    word_t   marOut;
    word_t   irOut;

    integer  seed = 32'h27a;
    int      errors = 0;
    int      checks = 0;
    bit      ready;
    word_t   lastBus;   // Bus value seen in the last driven cycle

    // Reference model of every register
    word_t   mReg [16] = '{default: '0};
    word_t   mHi = '0;
    word_t   mLo = '0;
    word_t   mPc = '0;
    word_t   mIr = '0;
    word_t   mMar = '0;
    word_t   mMdr = '0;
    word_t   mY = '0;
    dword_t  mZ = '0;

    // Single strobe patterns
    localparam busSrc_t hiSrc    = '{hiOut: 1'b1, default: '0};
    localparam busSrc_t loSrc    = '{loOut: 1'b1, default: '0};
    localparam busSrc_t pcSrc    = '{pcOut: 1'b1, default: '0};
    localparam busSrc_t mdrSrc   = '{mdrOut: 1'b1, default: '0};
    localparam busSrc_t zHighSrc = '{zHighOut: 1'b1, default: '0};
    localparam busSrc_t zLowSrc  = '{zLowOut: 1'b1, default: '0};
    localparam busDst_t hiDst    = '{hiIn: 1'b1, default: '0};
    localparam busDst_t loDst    = '{loIn: 1'b1, default: '0};
    localparam busDst_t pcDst    = '{pcIn: 1'b1, default: '0};
    localparam busDst_t irDst    = '{irIn: 1'b1, default: '0};
    localparam busDst_t marDst   = '{marIn: 1'b1, default: '0};
    localparam busDst_t mdrDst   = '{mdrIn: 1'b1, default: '0};
    localparam busDst_t yDst     = '{yIn: 1'b1, default: '0};
    localparam busDst_t zDst     = '{zIn: 1'b1, default: '0};

    datapath #(
        .wordWidth(32),
        .numRegs  (16)
    ) DUT (
        .clock  (clock),
        .rst    (rst),
        .ctrl   (ctrl),
        .mdataIn(mdataIn),
        .busOut (busOut),
        .marOut (marOut),
        .irOut  (irOut)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic checkWord(string name, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkDword(string name, dword_t expected, dword_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic busSrc_t regSrc(int n);
        busSrc_t s;
        s = '0;
        s.regOut[n] = 1'b1;
        return s;
    endfunction

    function automatic busDst_t regDst(int n);
        busDst_t d;
        d = '0;
        d.regIn[n] = 1'b1;
        return d;
    endfunction

    // Expected ALU result from the operation rules
    function automatic dword_t modelAlu(aluOp_t op, word_t a, word_t b, logic inc);
        int    n;
        word_t r;
        n = b[4:0];
        r = '0;
        if (inc) begin
            return {32'h0, b + 32'd1};
        end
        case (op)
            opAdd:   r = a + b;
            opSub:   r = a + ~b + 32'd1;
            opAnd:   r = a & b;
            opOr:    r = a | b;
            opShr:   r = a >> n;
            opShra:  r = (a >> n) | (a[31] ? ~(32'hffff_ffff >> n) : 32'h0);
            opShl:   r = a << n;
            opRor:   r = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
            opRol:   r = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
            opNot:   r = ~b;
            opNeg:   r = ~b + 32'd1;
            opMul:   return {32'h0, a} * {32'h0, b};
            default: r = '0;
        endcase
        return {32'h0, r};
    endfunction

    // Lowest register first, then the fixed order of the other sources
    function automatic word_t modelBus(busSrc_t s);
        for (int i = 0; i < 16; i++) begin
            if (s.regOut[i]) begin
                return mReg[i];
            end
        end
        if (s.hiOut) return mHi;
        else if (s.loOut) return mLo;
        else if (s.pcOut) return mPc;
        else if (s.mdrOut) return mMdr;
        else if (s.zHighOut) return mZ[63:32];
        else if (s.zLowOut) return mZ[31:0];
        return '0;
    endfunction

    // One control word for one cycle, model follows the same loads
    task automatic drive(busSrc_t s, busDst_t d, word_t mem = '0, logic rd = 1'b0,
                         logic inc = 1'b0, aluOp_t op = opAdd);
        word_t  expBus;
        dword_t zNext;
        @(posedge clock);
        ctrl    <= '{src: s, dst: d, read: rd, incPc: inc, op: op};
        mdataIn <= mem;
        @(negedge clock);
        lastBus = busOut;
        expBus  = modelBus(s);
        zNext   = modelAlu(op, mY, expBus, inc);
        checkWord("busOut", expBus, busOut);
        for (int i = 0; i < 16; i++) begin
            if (d.regIn[i]) mReg[i] = expBus;
        end
        if (d.hiIn) mHi = expBus;
        if (d.loIn) mLo = expBus;
        if (d.pcIn) mPc = expBus;
        if (d.irIn) mIr = expBus;
        if (d.marIn) mMar = expBus;
        if (d.mdrIn) mMdr = rd ? mem : expBus;
        if (d.yIn) mY = expBus;
        if (d.zIn) mZ = zNext;
        @(posedge clock);
        ctrl <= '0;
        @(negedge clock);
        checkWord("marOut", mMar, marOut);
        checkWord("irOut", mIr, irOut);
    endtask

    task automatic loadReg(int n, word_t v);
        drive('0, mdrDst, v, 1'b1);   // Memory word into MDR
        drive(mdrSrc, regDst(n));
    endtask

    task automatic expectReg(int n, word_t expected);
        drive(regSrc(n), '0);
        checkWord($sformatf("R%0d", n), expected, lastBus);
    endtask

    task automatic waitIdle(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < 20) begin
            @(negedge clock);
            ok = (rst == 1'b0) && (busOut === '0);
            cycles++;
        end
    endtask

    task automatic testResetAndLoad();
        word_t vals [16];
        drive(pcSrc, '0);
        checkWord("PC", '0, lastBus);
        drive(mdrSrc, '0);
        checkWord("MDR", '0, lastBus);
        for (int i = 0; i < 16; i++) begin
            expectReg(i, '0);
        end
        for (int i = 0; i < 16; i++) begin
            vals[i] = $random(seed);
            loadReg(i, vals[i]);
            expectReg(i, vals[i]);
        end
        for (int i = 0; i < 16; i++) begin
            expectReg(i, vals[i]);   // Still intact after the other loads
        end
    endtask

    task automatic testFetch();
        word_t startPc;
        word_t expPc;
        word_t mem;
        startPc = $random(seed);
        expPc   = startPc;
        drive('0, mdrDst, startPc, 1'b1);
        drive(mdrSrc, pcDst);
        repeat (3) begin
            mem = $random(seed);
            drive(pcSrc, marDst | zDst, '0, 1'b0, 1'b1);   // T0
            drive(zLowSrc, pcDst | mdrDst, mem, 1'b1);     // T1
            drive(mdrSrc, irDst);                          // T2
            checkWord("marOut", expPc, marOut);
            checkWord("irOut", mem, irOut);
            expPc = expPc + 32'd1;
            drive(pcSrc, '0);
            checkWord("PC", expPc, lastBus);
        end
        checkWord("PC after three fetches", startPc + 32'd3, lastBus);
    endtask

    task automatic aluCase(aluOp_t op);
        word_t  a;
        word_t  b;
        dword_t expected;
        a = $random(seed);
        b = $random(seed);
        expected = modelAlu(op, a, b, 1'b0);
        loadReg(1, a);
        loadReg(2, b);
        drive(regSrc(1), yDst);
        drive(regSrc(2), zDst, '0, 1'b0, 1'b0, op);
        drive(zLowSrc, regDst(3));
        expectReg(3, expected[31:0]);
    endtask

    task automatic testTwoOperand();
        aluOp_t ops [9] = '{opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol};
        for (int i = 0; i < 9; i++) begin
            aluCase(ops[i]);
        end
    endtask

    task automatic testOneOperandAndMul();
        word_t  v;
        word_t  a;
        word_t  b;
        word_t  hiWord;
        dword_t product;
        v = $random(seed);
        loadReg(7, v);
        drive(regSrc(7), zDst, '0, 1'b0, 1'b0, opNot);   // NOT R6, R7
        drive(zLowSrc, regDst(6));
        expectReg(6, ~v);
        drive(regSrc(7), zDst, '0, 1'b0, 1'b0, opNeg);
        drive(zLowSrc, regDst(6));
        expectReg(6, ~v + 32'd1);
        a = $random(seed);
        b = $random(seed);
        product = modelAlu(opMul, a, b, 1'b0);
        loadReg(1, a);
        loadReg(2, b);
        drive(regSrc(1), yDst);
        drive(regSrc(2), zDst, '0, 1'b0, 1'b0, opMul);
        drive(zHighSrc, hiDst);
        drive(zLowSrc, loDst);
        drive(hiSrc, '0);
        hiWord = lastBus;
        drive(loSrc, '0);
        checkDword("Z product", product, {hiWord, lastBus});
        // Code outside the table
        drive(regSrc(2), zDst, '0, 1'b0, 1'b0, aluOp_t'(5'b11111));
        drive(zLowSrc, regDst(3));
        expectReg(3, '0);
        drive(zHighSrc, '0);
        checkWord("Z high unused op", '0, lastBus);
    endtask

    task automatic testPriorityAndMdr();
        word_t a;
        word_t b;
        word_t mem;
        a = $random(seed);
        b = $random(seed);
        mem = ~b;
        loadReg(4, a);
        loadReg(9, b);
        $assertoff;
        drive(regSrc(4) | regSrc(9), '0);
        $asserton;
        checkWord("busOut two sources", a, lastBus);
        drive(regSrc(9), mdrDst, mem, 1'b0);   // Bus wins without read
        drive(mdrSrc, '0);
        checkWord("MDR", b, lastBus);
    endtask

    initial begin
        rst     = 1'b1;
        ctrl    = '0;
        mdataIn = '0;
        lastBus = '0;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        waitIdle(ready);
        if (ready) begin
            testResetAndLoad();
            testFetch();
            testTwoOperand();
            testOneOperandAndMul();
            testPriorityAndMdr();
        end else begin
            errors++;
            $display("bus did not go idle within 20 cycles after reset");
        end
        $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                 DUT.chk.failures);
        if ((errors == 0) && (DUT.chk.failures == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import datapathPkg::*; #(
    parameter int wordWidth = 32
) (
    input  word_t  a,       // Y register
    input  word_t  b,       // Bus
    input  aluOp_t op,
    input  logic   incPc,
    output dword_t result
);

    localparam int shW = $clog2(wordWidth);

    logic [shW-1:0]         shAmt;
    logic [2*wordWidth-1:0] rotR;
    logic [2*wordWidth-1:0] rotL;
    word_t                  sum;
    word_t                  diff;
    word_t                  incVal;
    word_t                  wordRes;
    dword_t                 product;

    // Shift amount from the low bits of the bus operand
    assign shAmt = b[shW-1:0];

    // Rotates through a doubled copy of a
    assign rotR = {a, a} >> shAmt; // Low half is a rotated right
    assign rotL = {a, a} << shAmt; // High half is a rotated left

    assign sum    = a + b;
    assign diff   = a - b;
    assign incVal = b + 1'b1;

    // Full unsigned product, both operands widened first
    assign product = dword_t'(a) * dword_t'(b);

    // Single word results, zero extended below
    always_comb begin
        case (op)
            opAdd: begin
                wordRes = sum;
            end
            opSub: begin
                wordRes = diff;
            end
            opAnd: begin
                wordRes = a & b;
            end
            opOr: begin
                wordRes = a | b;
            end
            opShr: begin
                wordRes = a >> shAmt;
            end
            opShra: begin
                wordRes = $signed(a) >>> shAmt; // Sign bit fills from the top
            end
            opShl: begin
                wordRes = a << shAmt;
            end
            opRor: begin
                wordRes = rotR[wordWidth-1:0];
            end
            opRol: begin
                wordRes = rotL[2*wordWidth-1:wordWidth];
            end
            opNot: begin
                wordRes = ~b;   // Operand comes from the bus alone
            end
            opNeg: begin
                wordRes = -b;   // Two's complement of the bus
            end
            default: begin
                wordRes = '0;   // Covers opMul and unused codes
            end
        endcase
    end

    // IncPC overrides the operation
    always_comb begin
        if (incPc) begin
            result = dword_t'(incVal);
        end else if (op == opMul) begin
            result = product;
        end else begin
            result = dword_t'(wordRes);
        end
    end

endmodule

`default_nettype wire

// ==== src/busMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module busMux import datapathPkg::*; #(
    parameter int wordWidth = 32,
    parameter int numRegs   = 16
) (
    input  busSrc_t src,
    input  word_t   regQ [numRegs],
    input  word_t   hi,
    input  word_t   lo,
    input  word_t   pc,
    input  word_t   mdr,
    input  dword_t  z,
    output word_t   bus
);

    localparam int selW = (numRegs > 1) ? $clog2(numRegs) : 1;

    busIndex_t       srcIdx;
    logic [selW-1:0] regSel;

    // Lowest numbered register out strobe wins
    always_comb begin
        regSel = '0;
        for (int i = numRegs - 1; i >= 0; i--) begin
            if (src.regOut[i]) begin
                regSel = selW'(i); // Scanned downward so the last hit is the lowest
            end
        end
    end

    // Source priority, registers above everything else
    always_comb begin
        if (|src.regOut) begin
            srcIdx = srcReg;
        end else if (src.hiOut) begin
            srcIdx = srcHi;
        end else if (src.loOut) begin
            srcIdx = srcLo;
        end else if (src.pcOut) begin
            srcIdx = srcPc;
        end else if (src.mdrOut) begin
            srcIdx = srcMdr;
        end else if (src.zHighOut) begin
            srcIdx = srcZHigh;
        end else if (src.zLowOut) begin
            srcIdx = srcZLow;
        end else begin
            srcIdx = srcNone;
        end
    end

    always_comb begin
        case (srcIdx)
            srcReg:   bus = regQ[regSel];
            srcHi:    bus = hi;
            srcLo:    bus = lo;
            srcPc:    bus = pc;
            srcMdr:   bus = mdr;
            srcZHigh: bus = z[wordWidth +: wordWidth];
            srcZLow:  bus = z[wordWidth-1:0];
            default:  bus = '0; // Idle bus reads zero
        endcase
    end

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath import datapathPkg::*; #(
    parameter int wordWidth = 32,
    parameter int numRegs   = 16
) (
    input  logic    clock,
    input  logic    rst,
    input  dpCtrl_t ctrl,
    input  word_t   mdataIn,  // From memory
    output word_t   busOut,
    output word_t   marOut,   // To memory
    output word_t   irOut
);

    word_t  bus;
    word_t  regQ [numRegs];
    word_t  hi;
    word_t  lo;

    // Special registers
    word_t  pc;
    word_t  ir;
    word_t  mar;
    word_t  mdr;
    word_t  y;
    dword_t z;

    dword_t aluResult;
    word_t  mdrNext;

    registerFile #(
        .wordWidth(wordWidth),
        .numRegs  (numRegs)
    ) regs (
        .clock(clock),
        .rst  (rst),
        .bus  (bus),
        .regIn(ctrl.dst.regIn),
        .hiIn (ctrl.dst.hiIn),
        .loIn (ctrl.dst.loIn),
        .regQ (regQ),
        .hi   (hi),
        .lo   (lo)
    );

    // Single driver onto the shared bus
    busMux #(
        .wordWidth(wordWidth),
        .numRegs  (numRegs)
    ) mux (
        .src (ctrl.src),
        .regQ(regQ),
        .hi  (hi),
        .lo  (lo),
        .pc  (pc),
        .mdr (mdr),
        .z   (z),
        .bus (bus)
    );

    // Y is operand A, the bus is operand B
    alu #(
        .wordWidth(wordWidth)
    ) aluUnit (
        .a     (y),
        .b     (bus),
        .op    (ctrl.op),
        .incPc (ctrl.incPc),
        .result(aluResult)
    );

    // Memory read bypasses the bus
    assign mdrNext = ctrl.read ? mdataIn : bus;

    // PC, IR and MAR all load straight from the bus
    always_ff @(posedge clock) begin
        if (rst) begin
            pc  <= '0;
            ir  <= '0;
            mar <= '0;
        end else begin
            if (ctrl.dst.pcIn) begin
                pc <= bus;
            end
            if (ctrl.dst.irIn) begin
                ir <= bus;
            end
            if (ctrl.dst.marIn) begin
                mar <= bus;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mdr <= '0;
        end else if (ctrl.dst.mdrIn) begin
            mdr <= mdrNext;
        end
    end

    // Y latches the first operand, Z the whole ALU result
    always_ff @(posedge clock) begin
        if (rst) begin
            y <= '0;
            z <= '0;
        end else begin
            if (ctrl.dst.yIn) begin
                y <= bus;
            end
            if (ctrl.dst.zIn) begin
                z <= aluResult;
            end
        end
    end

    assign busOut = bus;
    assign marOut = mar;
    assign irOut  = ir;

endmodule

`default_nettype wire

// ==== src/datapathPkg.sv ====
`default_nettype none

package datapathPkg;

    // Default widths, the same as the datapath defaults
    localparam int wordBits = 32;
    localparam int regCount = 16;

    typedef logic [wordBits-1:0]   word_t;
    typedef logic [2*wordBits-1:0] dword_t;   // Z register and ALU result
    typedef logic [regCount-1:0]   regMask_t; // One bit per general register

    // ALU operation codes
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShra = 5'b01000,
        opShl  = 5'b01001,
        opRor  = 5'b01010,
        opRol  = 5'b01011,
        opNot  = 5'b01100,
        opNeg  = 5'b01101,
        opMul  = 5'b01110
    } aluOp_t;

    // Encoded bus driver
    typedef enum logic [2:0] {
        srcNone,
        srcReg,
        srcHi,
        srcLo,
        srcPc,
        srcMdr,
        srcZHigh,
        srcZLow
    } busIndex_t;

    typedef struct packed {
        regMask_t regOut;
        logic     hiOut;
        logic     loOut;
        logic     pcOut;
        logic     mdrOut;
        logic     zHighOut;
        logic     zLowOut;
    } busSrc_t;

    typedef struct packed {
        regMask_t regIn;
        logic     hiIn;
        logic     loIn;
        logic     pcIn;
        logic     irIn;
        logic     marIn;
        logic     mdrIn;
        logic     yIn;
        logic     zIn;
    } busDst_t;

    // One control word per clock cycle
    typedef struct packed {
        busSrc_t src;
        busDst_t dst;
        logic    read;  // MDR takes mdataIn instead of the bus
        logic    incPc; // Z gets bus plus one
        aluOp_t  op;
    } dpCtrl_t;

endpackage

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile import datapathPkg::*; #(
    parameter int wordWidth = 32,
    parameter int numRegs   = 16
) (
    input  logic     clock,
    input  logic     rst,
    input  word_t    bus,
    input  regMask_t regIn,
    input  logic     hiIn,
    input  logic     loIn,
    output word_t    regQ [numRegs],
    output word_t    hi,
    output word_t    lo
);

    // General registers first, then HI and LO in the two top slots
    localparam int numSlots = numRegs + 2;
    localparam int hiSlot   = numRegs;
    localparam int loSlot   = numRegs + 1;

    logic [wordWidth-1:0] slots [numSlots];
    logic [numSlots-1:0]  load;

    assign load = {loIn, hiIn, regIn};

    // Any number of slots may take the same bus word in one cycle
    always_ff @(posedge clock) begin
        for (int i = 0; i < numSlots; i++) begin
            if (rst) begin
                slots[i] <= '0;
            end else if (load[i]) begin
                slots[i] <= bus;
            end
        end
    end

    // Reads are combinational
    for (genvar g = 0; g < numRegs; g++) begin : genRead
        assign regQ[g] = slots[g];
    end

    assign hi = slots[hiSlot];
    assign lo = slots[loSlot];

endmodule

`default_nettype wire

// ==== tb.f ====
src/datapathPkg.sv
src/registerFile.sv
src/busMux.sv
src/alu.sv
src/datapath.sv
sim/datapathAsserts.sv
sim/datapathTb.sv
